//--- src/obj_pkg.sv
package obj_pkg;

    typedef logic [3:0]  pxl_t;       // Colour index, 15 is see-through
    typedef logic [11:0] buf_pxl_t;   // prio(2) pal(6) colour(4)
    typedef logic [19:0] rom_addr_t;  // bank(4) word offset(16)
    typedef logic [15:0] rom_word_t;  // Four packed pixels
    typedef logic [8:0]  hpos_t;
    typedef logic [8:0]  vpos_t;

    // Eleven fields, 70 bits in all
    localparam int ATTR_W = 70;
    typedef logic [ATTR_W-1:0] obj_attr_t;

    localparam int ATTR_TOP_LSB    = 0;   // 9 bits, first line
    localparam int ATTR_BOTTOM_LSB = 9;   // 9 bits, last line
    localparam int ATTR_X_LSB      = 18;  // 9 bits
    localparam int ATTR_OFFSET_LSB = 27;  // 16 bits, word offset of row 0
    localparam int ATTR_PITCH_LSB  = 43;  // 8 bits, words per row
    localparam int ATTR_BANK_LSB   = 51;  // 4 bits
    localparam int ATTR_PRIO_LSB   = 55;  // 2 bits
    localparam int ATTR_PAL_LSB    = 57;  // 6 bits
    localparam int ATTR_HZOOM_LSB  = 63;  // 5 bits, 0 is full width
    localparam int ATTR_HFLIP_LSB  = 68;
    localparam int ATTR_EN_LSB     = 69;

    localparam pxl_t     PXL_TRANSP = 4'hf;
    localparam buf_pxl_t BUF_BLANK  = {8'h00, PXL_TRANSP};  // Cleared entry

    typedef enum logic [2:0] {
        S_IDLE, S_READ, S_CHECK, S_ISSUE, S_WAIT
    } scan_state_t;

    typedef enum logic [1:0] {
        D_IDLE, D_FETCH, D_DRAW
    } draw_state_t;

endpackage

//--- src/obj_req_if.sv
`timescale 1ns/1ps

// One sprite row handed from the scanner to the drawer
interface obj_req_if
    import obj_pkg::*;
();
    logic        start;   // One-cycle pulse, fields valid with it
    hpos_t       xpos;
    logic [15:0] offset;  // First word of the row
    logic [3:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [4:0]  hzoom;
    logic        hflip;
    logic        busy;    // Drawer still on a row

    modport scan (
        output start, xpos, offset, bank, prio, pal, hzoom, hflip,
        input  busy
    );

    modport draw (
        input  start, xpos, offset, bank, prio, pal, hzoom, hflip,
        output busy
    );

endinterface

//--- src/obj_scan.sv
`timescale 1ns/1ps

module obj_scan
    import obj_pkg::*;
#(
    parameter int OBJ_COUNT = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hstart,
    input  vpos_t                        vpos,
    input  logic                         tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0] tbl_addr,
    input  obj_attr_t                    tbl_data,
    output logic                         scan_done,
    obj_req_if.scan                      req
);

    localparam int IDX_W = $clog2(OBJ_COUNT);

    obj_attr_t        tbl [OBJ_COUNT];   // Attribute table
    obj_attr_t        attr;              // Entry read, valid from CHECK on
    logic [IDX_W-1:0] idx;
    vpos_t            line;              // Line being prepared
    scan_state_t      state;
    logic             hit;
    vpos_t            row;               // Row of the sprite on this line
    logic             issue;

    vpos_t       a_top;
    vpos_t       a_bottom;
    hpos_t       a_xpos;
    logic [15:0] a_ofs;
    logic [7:0]  a_pitch;
    logic [3:0]  a_bank;
    logic [1:0]  a_prio;
    logic [5:0]  a_pal;
    logic [4:0]  a_hzoom;
    logic        a_hflip;
    logic        a_en;
    logic [16:0] row_ofs;

    // Field views
    assign a_top    = attr[ATTR_TOP_LSB +: 9];
    assign a_bottom = attr[ATTR_BOTTOM_LSB +: 9];
    assign a_xpos   = attr[ATTR_X_LSB +: 9];
    assign a_ofs    = attr[ATTR_OFFSET_LSB +: 16];
    assign a_pitch  = attr[ATTR_PITCH_LSB +: 8];
    assign a_bank   = attr[ATTR_BANK_LSB +: 4];
    assign a_prio   = attr[ATTR_PRIO_LSB +: 2];
    assign a_pal    = attr[ATTR_PAL_LSB +: 6];
    assign a_hzoom  = attr[ATTR_HZOOM_LSB +: 5];
    assign a_hflip  = attr[ATTR_HFLIP_LSB];
    assign a_en     = attr[ATTR_EN_LSB];

    assign row_ofs = row * a_pitch;  // Words skipped to reach this row

    // Hand over only once the drawer is free
    assign issue = !hstart && (state == S_ISSUE || state == S_WAIT) && hit && !req.busy;

    // Table RAM, CPU writes and scanner reads
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_data;
        end
        attr <= tbl[idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            idx       <= '0;
            line      <= '0;
            hit       <= 1'b0;
            row       <= '0;
            scan_done <= 1'b0;
            req.start <= 1'b0;
        end else begin
            req.start <= issue;
            if (hstart) begin
                state     <= S_READ;  // Restart at entry 0
                idx       <= '0;
                line      <= vpos;
                scan_done <= 1'b0;
            end else begin
                case (state)
                    S_READ: state <= S_CHECK;  // RAM data next cycle
                    S_CHECK: begin
                        hit   <= a_en && (a_top <= line) && (line <= a_bottom);
                        row   <= line - a_top;
                        state <= S_ISSUE;
                    end
                    S_ISSUE, S_WAIT: begin
                        if (hit && req.busy) begin
                            state <= S_WAIT;   // Previous row not done
                        end else begin
                            idx <= idx + 1'b1;
                            if (&idx) begin
                                state     <= S_IDLE;
                                scan_done <= 1'b1;
                            end else begin
                                state <= S_READ;
                            end
                        end
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // Request fields
    always_ff @(posedge clk) begin
        if (issue) begin
            req.xpos   <= a_xpos;
            req.offset <= a_ofs + row_ofs[15:0];
            req.bank   <= a_bank;
            req.prio   <= a_prio;
            req.pal    <= a_pal;
            req.hzoom  <= a_hzoom;
            req.hflip  <= a_hflip;
        end
    end

    // Drawer must be free whenever a new row is handed over
    assert property (@(posedge clk) disable iff (rst) req.start |-> !req.busy)
        else $error("obj_scan: start while drawer busy");

endmodule

//--- src/obj_draw.sv
`timescale 1ns/1ps

module obj_draw
    import obj_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hstart,
    obj_req_if.draw   req,
    output logic      wb_cyc,
    output logic      wb_stb,
    output rom_addr_t wb_adr,
    input  rom_word_t wb_dat,
    input  logic      wb_ack,
    output logic      bf_we,
    output hpos_t     bf_addr,
    output buf_pxl_t  bf_data
);

    draw_state_t state;
    logic [15:0] cur;       // Word offset being fetched
    rom_word_t   pxl_data;  // Shifts one pixel per draw cycle
    logic [1:0]  cnt;       // Pixel within word
    logic [3:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [4:0]  hzoom;
    logic        hflip;
    logic [5:0]  hzacc;     // Shrink accumulator
    logic [6:0]  hzsum;
    logic        hzov;      // Carry drops the pixel
    pxl_t        cur_pxl;
    logic        take;

    // Flipped rows read the word from the low nibble
    assign cur_pxl = hflip ? pxl_data[3:0] : pxl_data[15:12];

    assign hzsum = {1'b0, hzacc} + {2'b00, hzoom};
    assign hzov  = hzsum[6];

    assign wb_adr  = {bank, cur};
    assign bf_we   = (state == D_DRAW) && !hzov && (cur_pxl != PXL_TRANSP);
    assign bf_data = {prio, pal, cur_pxl};

    assign take = (state == D_IDLE) && req.start;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= D_IDLE;
            req.busy <= 1'b0;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            cnt      <= '0;
        end else if (hstart) begin
            // Line over, drop whatever is in flight
            state    <= D_IDLE;
            req.busy <= 1'b0;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (req.start) begin
                        state    <= D_FETCH;
                        req.busy <= 1'b1;
                        wb_cyc   <= 1'b1;  // First request next cycle
                        wb_stb   <= 1'b1;
                    end
                end
                D_FETCH: begin
                    if (wb_ack) begin
                        state  <= D_DRAW;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        cnt    <= '0;
                    end
                end
                D_DRAW: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 2'd3) begin
                        if (cur_pxl == PXL_TRANSP) begin
                            state    <= D_IDLE;  // End marker reached
                            req.busy <= 1'b0;
                        end else begin
                            state  <= D_FETCH;
                            wb_cyc <= 1'b1;
                            wb_stb <= 1'b1;
                        end
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // Row data path
    always_ff @(posedge clk) begin
        if (take) begin
            cur     <= req.offset;
            bank    <= req.bank;
            prio    <= req.prio;
            pal     <= req.pal;
            hzoom   <= req.hzoom;
            hflip   <= req.hflip;
            hzacc   <= {req.hzoom[3:0], 2'b00};  // hzoom times 4
            bf_addr <= req.xpos;
        end else if (state == D_FETCH && wb_ack) begin
            pxl_data <= wb_dat;
        end else if (state == D_DRAW) begin
            pxl_data <= hflip ? pxl_data >> 4 : pxl_data << 4;
            hzacc    <= hzsum[5:0];
            if (!hzov) begin
                bf_addr <= bf_addr + 1'b1;  // Transparent still moves on
            end
            if (cnt == 2'd3) begin
                cur <= hflip ? cur - 1'b1 : cur + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("obj_draw: stb without cyc");

    // Request held with a steady address until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack && !hstart |=> wb_stb && $stable(wb_adr))
        else $error("obj_draw: request changed before ack");

    assert property (@(posedge clk) disable iff (rst) bf_we |-> bf_data[3:0] != PXL_TRANSP)
        else $error("obj_draw: transparent pixel written");

endmodule

//--- src/obj_line_buf.sv
`timescale 1ns/1ps

module obj_line_buf
    import obj_pkg::*;
#(
    parameter int LINE_W = 512
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hstart,
    input  logic     we,
    input  hpos_t    wr_addr,
    input  buf_pxl_t wr_data,
    input  hpos_t    rd_addr,
    output buf_pxl_t rd_data
);

    localparam int AW = $clog2(2 * LINE_W);

    buf_pxl_t      mem [2 * LINE_W];  // Both halves
    logic          sel;               // Half on screen
    logic [AW-1:0] front_base;
    logic [AW-1:0] back_base;
    logic [AW-1:0] rd_idx;
    logic [AW-1:0] wr_idx;

    // Video reads the front half, drawer fills the back one
    assign front_base = sel ? AW'(LINE_W) : '0;
    assign back_base  = sel ? '0 : AW'(LINE_W);
    assign rd_idx     = front_base + AW'(rd_addr);
    assign wr_idx     = back_base + AW'(wr_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (hstart) begin
            sel <= ~sel;  // Swap at every line start
        end
    end

    // Halves never overlap, so both ports can write in one cycle
    always_ff @(posedge clk) begin
        rd_data     <= mem[rd_idx];
        mem[rd_idx] <= BUF_BLANK;  // Clean for the next line
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

endmodule

//--- src/obj_top.sv
`timescale 1ns/1ps

module obj_top
    import obj_pkg::*;
#(
    parameter int OBJ_COUNT = 16,
    parameter int LINE_W    = 512
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hstart,
    input  vpos_t                        vpos,
    // CPU side table load
    input  logic                         tbl_we,
    input  logic [$clog2(OBJ_COUNT)-1:0] tbl_addr,
    input  obj_attr_t                    tbl_data,
    // Graphics ROM, Wishbone read-only master
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output rom_addr_t                    wb_adr_o,
    input  rom_word_t                    wb_dat_i,
    input  logic                         wb_ack_i,
    // Video read side
    input  hpos_t                        rd_addr,
    output buf_pxl_t                     rd_data,
    output logic                         scan_done
);

    logic     bf_we;
    hpos_t    bf_addr;
    buf_pxl_t bf_data;

    obj_req_if req_if ();  // Scanner to drawer

    obj_scan #(
        .OBJ_COUNT (OBJ_COUNT)
    ) u_scan (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vpos      (vpos),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .scan_done (scan_done),
        .req       (req_if.scan)
    );

    obj_draw u_draw (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .req     (req_if.draw),
        .wb_cyc  (wb_cyc_o),
        .wb_stb  (wb_stb_o),
        .wb_adr  (wb_adr_o),
        .wb_dat  (wb_dat_i),
        .wb_ack  (wb_ack_i),
        .bf_we   (bf_we),
        .bf_addr (bf_addr),
        .bf_data (bf_data)
    );

    obj_line_buf #(
        .LINE_W (LINE_W)
    ) u_line_buf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .we      (bf_we),
        .wr_addr (bf_addr),
        .wr_data (bf_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

//--- test/obj_tb_checks.sv
`timescale 1ns/1ps

// Reference line model plus the checking assertions
module obj_tb_checks
    import obj_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      hstart,
    input logic      wb_cyc,
    input logic      wb_stb,
    input logic      scan_done,
    input logic      build,      // Rebuild the expected line
    input logic      blank,      // Expect an all-clear line
    input logic      chk_on,     // Compare this read
    input vpos_t     line,
    input hpos_t     rd_addr,
    input buf_pxl_t  rd_data,
    input obj_attr_t tbl [16],
    input rom_word_t rom [4096]
);

    buf_pxl_t exp_line [512];
    hpos_t    rd_addr_q;
    logic     rd_vld = 1'b0;   // Read data due this cycle
    logic     hs_seen = 1'b0;  // Any line start since reset
    int       errors = 0;

    // Walk the table in order, later sprites overwrite earlier ones
    task automatic model_line();
        obj_attr_t a;
        rom_word_t w;
        pxl_t      p;
        int        x, acc, hz, sum, ofs, nw;
        for (int i = 0; i < 512; i++) exp_line[i] = BUF_BLANK;
        for (int i = 0; i < 16 && !blank; i++) begin
            a = tbl[i];
            if (a[ATTR_EN_LSB] && a[ATTR_TOP_LSB +: 9] <= line
                && line <= a[ATTR_BOTTOM_LSB +: 9]) begin
                ofs = (a[ATTR_OFFSET_LSB +: 16]
                       + (line - a[ATTR_TOP_LSB +: 9]) * a[ATTR_PITCH_LSB +: 8]) % 65536;
                x   = a[ATTR_X_LSB +: 9];
                hz  = a[ATTR_HZOOM_LSB +: 5];
                acc = (hz * 4) % 64;  // Accumulator seed
                nw  = 0;
                p   = 4'h0;
                do begin
                    w = rom[ofs % 4096];
                    for (int k = 0; k < 4; k++) begin
                        p   = a[ATTR_HFLIP_LSB] ? w[4*k +: 4] : w[12-4*k +: 4];
                        sum = acc + hz;
                        acc = sum % 64;
                        if (sum < 64) begin  // Carry drops the pixel
                            if (p != PXL_TRANSP)
                                exp_line[x] = {a[ATTR_PRIO_LSB +: 2], a[ATTR_PAL_LSB +: 6], p};
                            x = (x + 1) % 512;
                        end
                    end
                    ofs = a[ATTR_HFLIP_LSB] ? (ofs + 65535) % 65536 : (ofs + 1) % 65536;
                    nw++;
                end while (p != PXL_TRANSP && nw < 256);
            end
        end
    endtask

    always @(posedge clk) begin
        rd_vld    <= chk_on;
        rd_addr_q <= rd_addr;  // Data for it arrives next edge
        if (hstart) hs_seen <= 1'b1;
        if (build) model_line();
    end

    assert property (@(posedge clk) disable iff (rst) rd_vld |-> rd_data == exp_line[rd_addr_q])
        else begin
            errors++;
            $display("CHECK FAILED %s addr %0d expected %03h actual %03h", obj_tb.test_name,
                     $sampled(rd_addr_q), exp_line[$sampled(rd_addr_q)], $sampled(rd_data));
        end

    // Quiet bus until the first line
    assert property (@(posedge clk) disable iff (rst) !hs_seen |-> !wb_cyc && !wb_stb && !scan_done)
        else begin
            errors++;
            $display("Bus cycle or scan_done active after reset before any line start");
        end

    assert property (@(posedge clk) disable iff (rst) hstart |=> !wb_cyc && !wb_stb)
        else begin
            errors++;
            $display("Wishbone cycle still open one cycle after a line start");
        end

endmodule

//--- test/obj_tb.sv
`timescale 1ns/1ps

module obj_tb
    import obj_pkg::*;
();

    localparam int NUM_TESTS = 7;
    localparam int LINE_CYC  = 1200;
    localparam int IDLE_LINE = 500;  // No sprite covers it

    logic      clk = 1'b0;
    logic      rst, hstart, tbl_we, wb_cyc, wb_stb, wb_ack, scan_done;
    logic      build, blank, chk_on;
    vpos_t     vpos, chk_line;
    logic [3:0] tbl_addr;
    obj_attr_t tbl_data;
    rom_addr_t wb_adr;
    rom_word_t wb_dat;
    hpos_t     rd_addr;
    buf_pxl_t  rd_data;
    obj_attr_t shadow [16];   // Table as loaded
    rom_word_t rom [4096];
    logic [31:0] rng = 32'hcc07;
    int        ack_wait, err_mark, passes, fails;
    string     test_name;

    obj_top #(.OBJ_COUNT(16), .LINE_W(512)) dut_i (
        .clk(clk), .rst(rst), .hstart(hstart), .vpos(vpos), .tbl_we(tbl_we),
        .tbl_addr(tbl_addr), .tbl_data(tbl_data), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb),
        .wb_adr_o(wb_adr), .wb_dat_i(wb_dat), .wb_ack_i(wb_ack), .rd_addr(rd_addr),
        .rd_data(rd_data), .scan_done(scan_done)
    );

    obj_tb_checks chk_i (
        .clk(clk), .rst(rst), .hstart(hstart), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
        .scan_done(scan_done), .build(build), .blank(blank), .chk_on(chk_on),
        .line(chk_line), .rd_addr(rd_addr), .rd_data(rd_data), .tbl(shadow), .rom(rom)
    );

    initial forever #20 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic obj_attr_t make_attr(input logic en, input int top, bot, x, ofs, pitch,
                                            input int pal, hz, input logic flip);
        obj_attr_t a;
        a = '0;
        a[ATTR_EN_LSB] = en;
        a[ATTR_TOP_LSB +: 9] = top;
        a[ATTR_BOTTOM_LSB +: 9] = bot;
        a[ATTR_X_LSB +: 9] = x;
        a[ATTR_OFFSET_LSB +: 16] = ofs;
        a[ATTR_PITCH_LSB +: 8] = pitch;
        a[ATTR_PRIO_LSB +: 2] = 2'd1;
        a[ATTR_PAL_LSB +: 6] = pal;
        a[ATTR_HZOOM_LSB +: 5] = hz;
        a[ATTR_HFLIP_LSB] = flip;
        return a;
    endfunction

    // Wishbone ROM slave, 0 to 3 wait states
    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            ack_wait <= 0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (ack_wait == 0) begin
                wb_ack   <= 1'b1;
                wb_dat   <= rom[wb_adr[11:0]];
                ack_wait <= int'(xorshift() % 4);
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end else begin
            wb_ack <= 1'b0;
        end
    end

    task automatic set_entry(input int i, input obj_attr_t a);
        @(posedge clk);
        tbl_we   <= 1'b1;
        tbl_addr <= 4'(i);
        tbl_data <= a;
        shadow[i] = a;
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    task automatic clear_table();
        for (int i = 0; i < 16; i++) set_entry(i, '0);
    endtask

    // Last pixel in draw order of word n-1 becomes the end marker
    task automatic end_mark(input int ofs, n, input logic flip);
        if (flip) rom[(ofs - n + 1) % 4096][15:12] = 4'hf;
        else rom[(ofs + n - 1) % 4096][3:0] = 4'hf;
    endtask

    task automatic line_start(input int v);
        @(posedge clk);
        hstart <= 1'b1;
        vpos   <= vpos_t'(v);
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk);
        while (!(scan_done && !dut_i.req_if.busy && !dut_i.req_if.start));
    endtask

    task automatic load_model(input int v, input logic b);
        @(posedge clk);
        build    <= 1'b1;
        blank    <= b;
        chk_line <= vpos_t'(v);
        @(posedge clk);
        build <= 1'b0;
    endtask

    task automatic sweep(input logic on);
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            rd_addr <= hpos_t'(a);
            chk_on  <= on;
        end
        @(posedge clk);
        chk_on <= 1'b0;
        @(posedge clk);
    endtask

    // Draw line v, show it on the next line, optionally check the cleared pass
    task automatic check_line(input int v, input logic then_blank);
        line_start(v);
        wait_done();
        load_model(v, 1'b0);
        line_start(IDLE_LINE);
        sweep(1'b1);
        if (then_blank) begin
            line_start(IDLE_LINE);  // Other half on screen
            load_model(IDLE_LINE, 1'b1);
            line_start(IDLE_LINE);  // Back to the half just read out
            sweep(1'b1);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = chk_i.errors;
    endtask

    task automatic end_test();
        if (chk_i.errors == err_mark) begin
            passes++;
            $display("test %s: ok", test_name);
        end else begin
            fails++;
            $display("test %s: failed with %0d errors", test_name, chk_i.errors - err_mark);
        end
    endtask

    initial begin
        #(NUM_TESTS * 3 * LINE_CYC * 40);
        $display("Timeout: run did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int x;
        rst      = 1'b1;
        hstart   = 1'b0;
        vpos     = '0;
        tbl_we   = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        rd_addr  = '0;
        build    = 1'b0;
        blank    = 1'b0;
        chk_on   = 1'b0;
        chk_line = '0;
        wb_ack   = 1'b0;
        wb_dat   = '0;
        passes   = 0;
        fails    = 0;
        for (int i = 0; i < 4096; i++) rom[i] = 16'(xorshift() ^ 32'(i));
        begin_test("reset_idle");
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        clear_table();
        line_start(IDLE_LINE);  // Flush both halves once
        sweep(1'b0);
        line_start(IDLE_LINE);
        sweep(1'b0);
        end_test();

        begin_test("single_sprite");
        set_entry(0, make_attr(1, 100, 110, 40, 'h100, 8, 6'h12, 0, 0));
        end_mark('h100 + 5 * 8, 4, 0);
        check_line(105, 0);
        end_test();

        begin_test("hflip");
        set_entry(0, make_attr(1, 100, 110, 40, 'h180, 8, 6'h12, 0, 1));
        end_mark('h180 + 5 * 8, 4, 1);
        check_line(105, 0);
        end_test();

        begin_test("hzoom");
        set_entry(0, make_attr(1, 20, 30, 200, 'h200, 6, 6'h05, 6, 0));
        end_mark('h200, 6, 0);
        check_line(20, 0);
        end_test();

        begin_test("select_and_pitch");
        set_entry(0, make_attr(1, 50, 60, 300, 'h300, 12, 6'h21, 0, 0));
        set_entry(1, make_attr(1, 70, 80, 10, 'h380, 4, 6'h22, 0, 0));
        set_entry(2, make_attr(0, 40, 60, 100, 'h3c0, 4, 6'h23, 0, 0));
        end_mark('h300 + 24, 3, 0);
        check_line(52, 0);
        clear_table();
        end_test();

        begin_test("random_ack_and_clear");
        for (int i = 0; i < 3; i++) begin
            x = int'(xorshift() % 400);
            set_entry(i, make_attr(1, 300, 310, x, 'h400 + i * 'h40, 4, i + 1,
                                   int'(xorshift() % 32), xorshift() % 2 == 1));
            end_mark('h400 + i * 'h40 + 12, 5, shadow[i][ATTR_HFLIP_LSB]);
        end
        check_line(303, 1);
        clear_table();
        end_test();

        begin_test("hstart_abort");
        set_entry(0, make_attr(1, 200, 210, 0, 'h800, 16, 6'h30, 0, 0));
        line_start(200);
        do @(posedge clk);
        while (!wb_cyc);
        line_start(IDLE_LINE);  // Cuts the row short
        wait_done();
        load_model(IDLE_LINE, 1'b1);
        line_start(IDLE_LINE);  // Half a runaway row would have written
        sweep(1'b1);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
        if (fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
src/obj_pkg.sv
src/obj_req_if.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_line_buf.sv
src/obj_top.sv
test/obj_tb_checks.sv
test/obj_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the sprite pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module obj_tb -f verilog.f
./obj_dir/Vobj_tb | tee sim.log
if grep -q "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi
